// File: hdl/sd_dat_params.svh
// SD data path parameters
// block length, buffer address width and the DAT line CRC16 polynomial
// shared by the buffer, the arbiter, the controller and the CRC generator

`ifndef SD_DAT_PARAMS_SVH
`define SD_DAT_PARAMS_SVH

// bytes in one block, an even number (512 for a full size card block)
`define SD_BLK_BYTES 16

// byte address into the block buffer
`define SD_BUF_AW $clog2(`SD_BLK_BYTES)

// x^16 + x^12 + x^5 + 1, register starts at zero
`define SD_CRC_POLY 16'h1021

`endif

// File: hdl/sd_dat_pkg.sv
// SD DAT line types
// per cycle line phase and the transfer controller states

package sd_dat_pkg;

	// what every DAT line does in the current cycle
	typedef enum logic [2:0] {
		PH_OFF   = 3'd0, // released, receive side samples the pad
		PH_START = 3'd1, // drive the start bit
		PH_DATA  = 3'd2, // data bit, runs through the CRC
		PH_CRC   = 3'd3, // CRC remainder out, or compared on receive
		PH_STOP  = 3'd4  // drive the stop bit
	} dat_phase_e;

	typedef enum logic [3:0] {
		ST_IDLE, ST_PREFETCH,
		ST_TX_START, ST_TX_DATA, ST_TX_CRC, ST_TX_STOP,
		ST_RX_WAIT, ST_RX_DATA, ST_RX_CRC,
		ST_DONE
	} ctrl_state_e;

endpackage

// File: hdl/sd_buf_pkg.sv
// SD block buffer sharing types
// identifies which requester holds the single buffer port

package sd_buf_pkg;

	// owner of the buffer port in a given cycle
	typedef enum logic [1:0] {
		OWN_NONE = 2'd0, // port unused
		OWN_CTRL = 2'd1, // DAT controller
		OWN_HOST = 2'd2  // host port
	} buf_owner_e;

endpackage

// File: hdl/sd_crc16.sv
// Serial CRC16 for one DAT line
// accumulates data bits while gen_en is high, then shifts the
// remainder out MSB first while out_en is high

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module sd_crc16 (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic gen_en,
	input  logic out_en,
	input  logic din,
	output logic dout
);

	logic [15:0] crc;
	logic        fb; // feedback into the polynomial taps

	assign fb   = din ^ crc[15];
	assign dout = crc[15];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			crc <= '0;
		end
		else if (clr)
		begin
			crc <= '0; // new frame
		end
		else if (gen_en)
		begin
			crc <= {crc[14:0], 1'b0} ^ (fb ? `SD_CRC_POLY : 16'h0000);
		end
		else if (out_en)
		begin
			// remainder goes out on dout, zeros fill from below
			crc <= {crc[14:0], 1'b0};
		end
	end

endmodule

// File: hdl/sd_dat_line.sv
// One SD DAT line
// turns the phase into a pad bit, registers dat_out and dat_oe,
// delays dat_in through two samplers and runs the line's CRC16

`timescale 1ns/1ns

module sd_dat_line (
	input  logic                   clk,
	input  logic                   rst,
	input  sd_dat_pkg::dat_phase_e phase,
	input  logic                   tx_bit,
	input  logic                   crc_clr,
	input  logic                   dat_in,
	output logic                   dat_out,
	output logic                   dat_oe,
	output logic                   rx_bit,
	output logic                   crc_error
);

	logic       tx_mode; // set by a start bit, so the frame is ours to drive
	logic       drive;
	logic       out_bit;
	logic [1:0] dat_dly;
	logic       gen_en;
	logic       out_en;
	logic       crc_din;
	logic       crc_dout;

	assign gen_en  = (phase == sd_dat_pkg::PH_DATA);
	assign out_en  = (phase == sd_dat_pkg::PH_CRC);
	assign drive   = (phase == sd_dat_pkg::PH_START) |
		(tx_mode & (phase != sd_dat_pkg::PH_OFF));
	assign rx_bit  = dat_dly[1];
	assign crc_din = tx_mode ? out_bit : rx_bit; // sent bit or received bit

	always_comb
	begin
		case (phase)
			sd_dat_pkg::PH_START: out_bit = 1'b0;
			sd_dat_pkg::PH_DATA:  out_bit = tx_bit;
			sd_dat_pkg::PH_CRC:   out_bit = crc_dout;
			default:              out_bit = 1'b1; // stop bit and idle level
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_mode   <= 1'b0;
			dat_out   <= 1'b1;
			dat_oe    <= 1'b0;
			dat_dly   <= 2'b11; // bus idles high
			crc_error <= 1'b0;
		end
		else
		begin
			if (phase == sd_dat_pkg::PH_START)
				tx_mode <= 1'b1;
			else if (phase == sd_dat_pkg::PH_OFF)
				tx_mode <= 1'b0;
			dat_out <= out_bit;
			dat_oe  <= drive;
			if (!dat_oe)
				dat_dly <= {dat_dly[0], dat_in}; // frozen while we drive
			if (crc_clr)
				crc_error <= 1'b0;
			else if (out_en && !tx_mode && (crc_dout != rx_bit))
				crc_error <= 1'b1; // sticky until next frame
		end
	end

	sd_crc16 u_crc16 (
		.clk    (clk),
		.rst    (rst),
		.clr    (crc_clr),
		.gen_en (gen_en),
		.out_en (out_en),
		.din    (crc_din),
		.dout   (crc_dout)
	);

	// the pad is released one cycle after the phase goes off
	a_off_release: assert property (@(posedge clk) disable iff (rst)
		(phase == sd_dat_pkg::PH_OFF) |=> !dat_oe);

endmodule

// File: hdl/sd_dat_ctrl.sv
// SD DAT transfer controller
// moves one block between the buffer and the four DAT lines,
// fetching bytes ahead on transmit and packing nibbles on receive

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module sd_dat_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start_tx,
	input  logic                   start_rx,
	output logic                   busy,
	output logic                   done,
	output logic                   crc_error,
	output logic                   ctrl_req,
	output logic                   ctrl_we,
	output logic [`SD_BUF_AW-1:0]  ctrl_addr,
	output logic [7:0]             ctrl_wdata,
	input  logic [7:0]             buf_rdata,
	output sd_dat_pkg::dat_phase_e phase,
	output logic [3:0]             tx_bits,
	output logic                   crc_clr,
	input  logic [3:0]             rx_bits,
	input  logic [3:0]             line_crc_error
);

	localparam int AW = `SD_BUF_AW;
	localparam int CW = AW + 1; // counts nibbles of a block
	localparam logic [CW-1:0] DATA_LAST = CW'(2 * `SD_BLK_BYTES - 1);
	localparam logic [CW-1:0] CRC_LAST  = CW'(15);
	localparam logic [AW-1:0] LAST_BYTE = AW'(`SD_BLK_BYTES - 1);

	sd_dat_pkg::ctrl_state_e state, state_nxt;
	logic [CW-1:0] cnt;
	logic [AW-1:0] byte_idx;
	logic [7:0]    hold;  // byte on the lines now
	logic [3:0]    rx_hi; // high nibble waiting for its partner
	logic          start;

	assign start    = (state == sd_dat_pkg::ST_IDLE) & (start_tx | start_rx);
	assign byte_idx = cnt[CW-1:1];

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			sd_dat_pkg::ST_IDLE:
			begin
				if (start_tx)
					state_nxt = sd_dat_pkg::ST_PREFETCH;
				else if (start_rx)
					state_nxt = sd_dat_pkg::ST_RX_WAIT;
			end
			sd_dat_pkg::ST_PREFETCH: if (cnt[0]) state_nxt = sd_dat_pkg::ST_TX_START;
			sd_dat_pkg::ST_TX_START: state_nxt = sd_dat_pkg::ST_TX_DATA;
			sd_dat_pkg::ST_TX_DATA:  if (cnt == DATA_LAST) state_nxt = sd_dat_pkg::ST_TX_CRC;
			sd_dat_pkg::ST_TX_CRC:   if (cnt == CRC_LAST) state_nxt = sd_dat_pkg::ST_TX_STOP;
			sd_dat_pkg::ST_TX_STOP:  state_nxt = sd_dat_pkg::ST_DONE;
			sd_dat_pkg::ST_RX_WAIT:  if (!rx_bits[0]) state_nxt = sd_dat_pkg::ST_RX_DATA;
			sd_dat_pkg::ST_RX_DATA:  if (cnt == DATA_LAST) state_nxt = sd_dat_pkg::ST_RX_CRC;
			sd_dat_pkg::ST_RX_CRC:   if (cnt == CRC_LAST) state_nxt = sd_dat_pkg::ST_DONE;
			default:                 state_nxt = sd_dat_pkg::ST_IDLE; // done lasts one cycle
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= sd_dat_pkg::ST_IDLE;
			cnt       <= '0;
			done      <= 1'b0;
			crc_error <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			cnt   <= (state_nxt != state) ? '0 : cnt + 1'b1; // restarts per state
			done  <= (state == sd_dat_pkg::ST_DONE);
			if (start)
				crc_error <= 1'b0;
			else if (state == sd_dat_pkg::ST_DONE)
				crc_error <= |line_crc_error;
		end
	end

	always_ff @(posedge clk)
	begin
		// next byte lands as the low nibble of the current one goes out
		if ((state == sd_dat_pkg::ST_PREFETCH && cnt[0]) ||
			(state == sd_dat_pkg::ST_TX_DATA && cnt[0]))
			hold <= buf_rdata;
		if (state == sd_dat_pkg::ST_RX_DATA && !cnt[0])
			rx_hi <= rx_bits;
	end

	//////////////////////////////////////////////////////////////////////
	// line and buffer side
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			sd_dat_pkg::ST_TX_START: phase = sd_dat_pkg::PH_START;
			sd_dat_pkg::ST_TX_DATA,
			sd_dat_pkg::ST_RX_DATA:  phase = sd_dat_pkg::PH_DATA;
			sd_dat_pkg::ST_TX_CRC,
			sd_dat_pkg::ST_RX_CRC:   phase = sd_dat_pkg::PH_CRC;
			sd_dat_pkg::ST_TX_STOP:  phase = sd_dat_pkg::PH_STOP;
			default:                 phase = sd_dat_pkg::PH_OFF;
		endcase
	end

	always_comb
	begin
		case (state)
			sd_dat_pkg::ST_PREFETCH: ctrl_addr = '0;
			sd_dat_pkg::ST_TX_DATA:  ctrl_addr = byte_idx + 1'b1; // one byte ahead
			default:                 ctrl_addr = byte_idx;
		endcase
	end

	assign busy       = (state != sd_dat_pkg::ST_IDLE);
	assign tx_bits    = cnt[0] ? hold[3:0] : hold[7:4]; // high nibble first
	assign crc_clr    = (state == sd_dat_pkg::ST_TX_START) |
		((state == sd_dat_pkg::ST_RX_WAIT) & ~rx_bits[0]);
	assign ctrl_we    = (state == sd_dat_pkg::ST_RX_DATA);
	assign ctrl_wdata = {rx_hi, rx_bits};
	assign ctrl_req   = ((state == sd_dat_pkg::ST_PREFETCH) & ~cnt[0]) |
		((state == sd_dat_pkg::ST_TX_DATA) & ~cnt[0] & (byte_idx != LAST_BYTE)) |
		((state == sd_dat_pkg::ST_RX_DATA) & cnt[0]); // write on the low nibble

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == sd_dat_pkg::ST_IDLE) |-> !ctrl_req);

endmodule

// File: hdl/sd_buf_arbiter.sv
// Block buffer arbiter
// fixed priority for the DAT controller, the host waits for host_gnt;
// the owner is kept for the read-return cycle to hold host_rdata

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module sd_buf_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  ctrl_req,
	input  logic                  ctrl_we,
	input  logic [`SD_BUF_AW-1:0] ctrl_addr,
	input  logic [7:0]            ctrl_wdata,
	input  logic                  host_req,
	input  logic                  host_we,
	input  logic [`SD_BUF_AW-1:0] host_addr,
	input  logic [7:0]            host_wdata,
	output logic                  host_gnt,
	output logic                  buf_en,
	output logic                  buf_we,
	output logic [`SD_BUF_AW-1:0] buf_addr,
	output logic [7:0]            buf_wdata,
	input  logic [7:0]            buf_rdata,
	output logic [7:0]            host_rdata
);

	sd_buf_pkg::buf_owner_e owner, owner_q;
	logic       rd_q;        // last access was a read
	logic [7:0] host_rdata_q;

	assign owner = ctrl_req ? sd_buf_pkg::OWN_CTRL :
		host_req ? sd_buf_pkg::OWN_HOST : sd_buf_pkg::OWN_NONE;

	assign host_gnt  = host_req & ~ctrl_req;
	assign buf_en    = ctrl_req | host_req;
	assign buf_we    = ctrl_req ? ctrl_we : host_we;
	assign buf_addr  = ctrl_req ? ctrl_addr : host_addr;
	assign buf_wdata = ctrl_req ? ctrl_wdata : host_wdata;

	// host sees fresh data after its own read, else the held copy
	assign host_rdata = (owner_q == sd_buf_pkg::OWN_HOST && rd_q) ? buf_rdata : host_rdata_q;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			owner_q <= sd_buf_pkg::OWN_NONE;
			rd_q    <= 1'b0;
		end
		else
		begin
			owner_q <= owner;
			rd_q    <= buf_en & ~buf_we;
		end
	end

	always_ff @(posedge clk)
		host_rdata_q <= host_rdata;

	a_ctrl_first: assert property (@(posedge clk) disable iff (rst)
		!(host_gnt && ctrl_req));

endmodule

// File: hdl/sd_block_buf.sv
// SD block buffer
// single-port byte memory for one block, write on en and we,
// registered read data otherwise

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module sd_block_buf (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  logic [`SD_BUF_AW-1:0] addr,
	input  logic [7:0]            wdata,
	output logic [7:0]            rdata
);

	logic [7:0] mem [0:`SD_BLK_BYTES-1];

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // kept until the next read
		end
	end

endmodule

// File: hdl/sd_dat_path.sv
// SD host DAT data path, four lines
// block buffer shared by the host and the DAT controller,
// with one line slice per DAT pad

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module sd_dat_path (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_tx,
	input  logic                  start_rx,
	output logic                  busy,
	output logic                  done,
	output logic                  crc_error,
	input  logic                  host_req,
	input  logic                  host_we,
	input  logic [`SD_BUF_AW-1:0] host_addr,
	input  logic [7:0]            host_wdata,
	output logic                  host_gnt,
	output logic [7:0]            host_rdata,
	input  logic [3:0]            dat_in,
	output logic [3:0]            dat_out,
	output logic [3:0]            dat_oe
);

	logic                   ctrl_req, ctrl_we;
	logic [`SD_BUF_AW-1:0]  ctrl_addr;
	logic [7:0]             ctrl_wdata;
	logic                   buf_en, buf_we;
	logic [`SD_BUF_AW-1:0]  buf_addr;
	logic [7:0]             buf_wdata, buf_rdata;
	sd_dat_pkg::dat_phase_e phase;
	logic [3:0]             tx_bits, rx_bits, line_crc_error;
	logic                   crc_clr;

	sd_block_buf u_block_buf (
		.clk (clk), .en (buf_en), .we (buf_we),
		.addr (buf_addr), .wdata (buf_wdata), .rdata (buf_rdata)
	);

	sd_buf_arbiter u_buf_arbiter (
		.clk (clk), .rst (rst),
		.ctrl_req (ctrl_req), .ctrl_we (ctrl_we),
		.ctrl_addr (ctrl_addr), .ctrl_wdata (ctrl_wdata),
		.host_req (host_req), .host_we (host_we),
		.host_addr (host_addr), .host_wdata (host_wdata), .host_gnt (host_gnt),
		.buf_en (buf_en), .buf_we (buf_we), .buf_addr (buf_addr),
		.buf_wdata (buf_wdata), .buf_rdata (buf_rdata), .host_rdata (host_rdata)
	);

	sd_dat_ctrl u_dat_ctrl (
		.clk (clk), .rst (rst), .start_tx (start_tx), .start_rx (start_rx),
		.busy (busy), .done (done), .crc_error (crc_error),
		.ctrl_req (ctrl_req), .ctrl_we (ctrl_we),
		.ctrl_addr (ctrl_addr), .ctrl_wdata (ctrl_wdata), .buf_rdata (buf_rdata),
		.phase (phase), .tx_bits (tx_bits), .crc_clr (crc_clr),
		.rx_bits (rx_bits), .line_crc_error (line_crc_error)
	);

	// line i carries bit i of each nibble
	for (genvar i = 0; i < 4; i++)
	begin : g_line
		sd_dat_line u_dat_line (
			.clk (clk), .rst (rst), .phase (phase), .tx_bit (tx_bits[i]),
			.crc_clr (crc_clr), .dat_in (dat_in[i]), .dat_out (dat_out[i]),
			.dat_oe (dat_oe[i]), .rx_bit (rx_bits[i]), .crc_error (line_crc_error[i])
		);
	end

endmodule

// File: tests/tb_sd_dat_path.sv
// Testbench for the SD DAT data path
// reads host and transfer steps from a stimulus file, models the card
// side of the four DAT lines and checks frames, CRC flags and buffer data

`timescale 1ns/1ns

`include "sd_dat_params.svh"

module tb_sd_dat_path;

	localparam int B        = `SD_BLK_BYTES;
	localparam int NBIT     = 2 * B + 18; // start, data, crc, stop
	localparam int STEP_CYC = 4 * (2 * B + 20);

	logic                  clk, rst;
	logic                  start_tx, start_rx;
	logic                  busy, done, crc_error;
	logic                  host_req, host_we, host_gnt;
	logic [`SD_BUF_AW-1:0] host_addr;
	logic [7:0]            host_wdata, host_rdata;
	logic [3:0]            dat_in, dat_out, dat_oe;

	logic [7:0]  model_mem [0:B-1]; // what the buffer should hold
	logic [31:0] rnd = 32'd77;
	int          limit = 200;
	int          cyc = 0;

	sd_dat_path u_sd_dat_path (
		.clk (clk), .rst (rst), .start_tx (start_tx), .start_rx (start_rx),
		.busy (busy), .done (done), .crc_error (crc_error),
		.host_req (host_req), .host_we (host_we), .host_addr (host_addr),
		.host_wdata (host_wdata), .host_gnt (host_gnt), .host_rdata (host_rdata),
		.dat_in (dat_in), .dat_out (dat_out), .dat_oe (dat_oe)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// grows by one step budget each time a step is read
	initial
	begin
		forever
		begin
			@(posedge clk);
			cyc++;
			if (cyc > limit)
			begin
				$display("timeout: the DUT stopped making progress after %0d cycles", cyc);
				$display("CHECKS FAILED");
				$fatal(1);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// models
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// bit d of one line's data with the high nibble of each byte first
	function automatic logic data_bit(input int line, input int d);
		logic [7:0] b;
		b = model_mem[d / 2];
		return (d % 2 == 0) ? b[4 + line] : b[line];
	endfunction

	// remainder of the line's data times x^16 divided by the generator
	function automatic logic [15:0] line_crc(input int line);
		logic [16:0] r;
		r = 17'h00000;
		for (int d = 0; d < 2 * B + 16; d++)
		begin
			r = {r[15:0], (d < 2 * B) ? data_bit(line, d) : 1'b0};
			if (r[16])
				r = r ^ {1'b1, `SD_CRC_POLY};
		end
		return r[15:0];
	endfunction

	function automatic logic frame_bit(input int line, input int k, input logic [15:0] crc);
		if (k == 0)
			return 1'b0;
		else if (k <= 2 * B)
			return data_bit(line, k - 1);
		else if (k <= 2 * B + 16)
			return crc[15 - (k - 1 - 2 * B)]; // msb first
		return 1'b1;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////////////////////////

	// starts and ends on a falling edge
	task automatic host_access(input logic we, input int addr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int gap;
		rnd = xorshift(rnd);
		gap = int'(rnd[2:0]);
		repeat (gap) @(negedge clk);
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = addr[`SD_BUF_AW-1:0];
		host_wdata = wdata;
		#1;
		while (!host_gnt)
		begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		host_req = 1'b0;
		host_we  = 1'b0;
		rdata    = host_rdata; // one cycle after the grant
	endtask

	task automatic send_block();
		logic [15:0] crc [4];
		logic [7:0]  rd;
		for (int l = 0; l < 4; l++)
			crc[l] = line_crc(l);
		fork
			begin
				start_tx = 1'b1;
				@(negedge clk);
				start_tx = 1'b0;
				while (dat_oe !== 4'hf)
					@(negedge clk);
				for (int k = 0; k < NBIT; k++)
				begin
					check_val(dat_oe, 4'hf, "pads enabled during frame");
					check_val({busy, crc_error}, 2'b10, "busy with crc error cleared");
					for (int l = 0; l < 4; l++)
						check_val(dat_out[l], frame_bit(l, k, crc[l]), "transmit frame bit");
					start_tx = (k == 5); // a strobe while busy is ignored
					@(negedge clk);
				end
				start_tx = 1'b0;
				check_val(dat_oe, 4'h0, "pads released after stop bit");
				check_val({done, busy, crc_error}, 3'b100, "done after transmit");
				repeat (8)
				begin
					@(negedge clk);
					check_val({dat_oe, busy, done}, 6'b0, "quiet after transmit");
				end
			end
			begin
				for (int a = 0; a < B; a++)
				begin
					host_access(1'b0, a, 8'h00, rd);
					check_val(rd, model_mem[a], "host read during transmit");
				end
			end
		join
	endtask

	// card model sends the block and flips crc bit cb on line cl when cl < 4
	task automatic receive_block(input int cl, input int cb, input logic exp_err);
		logic [15:0] crc [4];
		logic [3:0]  v;
		for (int l = 0; l < 4; l++)
			crc[l] = line_crc(l);
		if (cl < 4)
			crc[cl][cb] = ~crc[cl][cb];
		start_rx = 1'b1;
		@(negedge clk);
		start_rx = 1'b0;
		check_val({busy, crc_error}, 2'b10, "receive started with crc error cleared");
		repeat (3) @(negedge clk);
		for (int k = 0; k < NBIT; k++)
		begin
			for (int l = 0; l < 4; l++)
				v[l] = frame_bit(l, k, crc[l]);
			dat_in = v;
			@(negedge clk);
		end
		dat_in = 4'hf;
		while (!done)
			@(negedge clk);
		check_val(crc_error, exp_err, "receive crc error flag");
		check_val({dat_oe, busy}, 5'b0, "pads released and idle after receive");
	endtask

	//////////////////////////////////////////////////////////////////////
	// step reader
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int         fd, code, a, d, cl, cb, e;
		logic [7:0] ch, rd;
		string      line;
		rst        = 1'b1;
		start_tx   = 1'b0;
		start_rx   = 1'b0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = 8'h00;
		dat_in     = 4'hf; // bus idles high
		repeat (3) @(negedge clk);
		rst = 1'b0;
		check_val({dat_oe, busy, done, host_gnt}, 7'b0, "outputs after reset");
		fd = $fopen("tests/sd_dat_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file tests/sd_dat_stim.txt");
			$display("CHECKS FAILED");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			code = $fscanf(fd, " %c", ch);
			if (code != 1)
				break;
			limit += STEP_CYC;
			case (ch)
				"#": code = $fgets(line, fd);
				"W":
				begin
					code = $fscanf(fd, " %h %h", a, d);
					host_access(1'b1, a, d[7:0], rd);
					model_mem[a] = d[7:0];
				end
				"C":
				begin
					code = $fscanf(fd, " %h %h", a, d);
					host_access(1'b0, a, 8'h00, rd);
					check_val(rd, d[7:0], "host read");
				end
				"T": send_block();
				"R":
				begin
					code = $fscanf(fd, " %d %d %d", cl, cb, e);
					for (int i = 0; i < B; i++)
					begin
						code = $fscanf(fd, " %h", d);
						model_mem[i] = d[7:0];
					end
					receive_block(cl, cb, e[0]);
				end
				default:
				begin
					$display("unknown step type in the stimulus file");
					$display("CHECKS FAILED");
					$fatal(1);
				end
			endcase
		end
		$fclose(fd);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: tests/sd_dat_stim.txt
# W addr data | C addr expected | T transmit the buffer and check the frame
# R crc_line crc_bit expected_crc_error (line 4 means clean) then the block bytes
R 4 0 0 3c a5 0f f0 12 34 56 78 9a bc de 01 80 7e c3 55
C 0 3c
C 7 78
C f 55
W 2 c4
W 5 19
W b e2
W e 6d
C 2 c4
C 5 19
C b e2
C e 6d
T
R 2 9 1 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
C 3 33
C c cc
T
R 0 15 1 e7 18 5a a5 c6 39 00 ff 6b 94 2d d2 71 8e b4 4b
C 9 94
R 3 0 1 e7 18 5a a5 c6 39 00 ff 6b 94 2d d2 71 8e b4 4b
W 0 81
C 0 81
T

// File: sd_dat_path.f
+incdir+hdl
hdl/sd_dat_pkg.sv
hdl/sd_buf_pkg.sv
hdl/sd_crc16.sv
hdl/sd_dat_line.sv
hdl/sd_dat_ctrl.sv
hdl/sd_buf_arbiter.sv
hdl/sd_block_buf.sv
hdl/sd_dat_path.sv
tests/tb_sd_dat_path.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sd_dat_path.f --top-module tb_sd_dat_path -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
